//--- design/vga_pkg.sv
package vga_pkg;

  // horizontal timing, counted in pixel clocks
  localparam int H_ACTIVE     = 640;
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_END   = 752;
  localparam int H_TOTAL      = 800;

  // vertical timing, counted in lines
  localparam int V_ACTIVE     = 480;
  localparam int V_SYNC_START = 490;
  localparam int V_SYNC_END   = 492;
  localparam int V_TOTAL      = 525;

  // 160x120 image, two 8-bit pixels per 16-bit word
  localparam int VRAM_AW    = 14;
  localparam int VRAM_WORDS = 9600;

  // address reg, ram read, colour reg
  localparam int PIPE_LAT = 3;

  typedef struct packed {
    logic [9:0] h;
    logic [9:0] v;
    logic       display;
    logic       hsync_n;
    logic       vsync_n;
  } scan_t;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // blank position with both syncs released
  localparam scan_t SCAN_IDLE = '{h: '0, v: '0, display: 1'b0, hsync_n: 1'b1, vsync_n: 1'b1};

  // 2-bit channel to 4 bits, 01 becomes 0101 etc
  function automatic logic [3:0] expand_channel(input logic [1:0] chan);
    return {chan, chan};
  endfunction

endpackage

//--- design/stage_delay.sv
`timescale 1ns/1ps

module stage_delay #(
  parameter type      payload_t = logic [7:0],
  parameter int       DEPTH     = 1,
  parameter payload_t IDLE      = payload_t'('0)
) (
  input  logic     clk_out,
  input  logic     reset,
  input  payload_t in_data,
  output payload_t out_data
);

  // one entry per pipeline stage
  payload_t pipe_q [DEPTH];

  always_ff @(posedge clk_out) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        pipe_q[i] <= IDLE;
      end
    end else begin
      pipe_q[0] <= in_data;
      for (int i = 1; i < DEPTH; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  assign out_data = pipe_q[DEPTH-1];

endmodule

//--- design/video_ram.sv
`timescale 1ns/1ps

module video_ram #(
  parameter int NUM_WORDS = vga_pkg::VRAM_WORDS
) (
  input  logic                        clk_out,
  input  logic                        wr_en,
  input  logic [vga_pkg::VRAM_AW-1:0] wr_addr,
  input  logic [15:0]                 wr_data,
  input  logic [vga_pkg::VRAM_AW-1:0] rd_addr,
  output logic [15:0]                 rd_data
);

  // image store, infers one block ram
  logic [15:0] mem [NUM_WORDS];

  // loader side
  always_ff @(posedge clk_out) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // scan side, one cycle read latency
  always_ff @(posedge clk_out) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- design/spi_flash_loader.sv
`timescale 1ns/1ps

module spi_flash_loader #(
  parameter logic [23:0] FLASH_BASE = 24'h000000,
  parameter int          NUM_WORDS  = vga_pkg::VRAM_WORDS
) (
  input  logic                        clk_out,
  input  logic                        reset,
  output logic                        spi_cs_n,
  output logic                        spi_sclk,
  output logic                        spi_mosi,
  input  logic                        spi_miso,
  output logic                        wr_en,
  output logic [vga_pkg::VRAM_AW-1:0] wr_addr,
  output logic [15:0]                 wr_data,
  output logic                        loaded
);
  import vga_pkg::*;

  // plain serial read, no dummy byte
  localparam logic [7:0] CMD_READ = 8'h03;

  typedef enum logic [2:0] {
    ST_START,
    ST_CMD,
    ST_ADDR,
    ST_DATA,
    ST_DONE
  } state_t;

  state_t               state;
  logic [31:0]          hdr_q;
  logic [4:0]           bit_cnt;
  logic [15:0]          word_q;
  logic [15:0]          word_next;
  logic [VRAM_AW-1:0]   word_cnt;
  logic                 rise;
  logic                 hdr_last;

  // sclk runs at half rate, low half shifts mosi, high half is sampled
  assign rise      = !spi_sclk;
  assign spi_mosi  = hdr_q[31];
  assign word_next = {word_q[14:0], spi_miso};
  // last falling edge of command or address phase
  assign hdr_last  = (state == ST_CMD && bit_cnt == 5'd7) ||
                     (state == ST_ADDR && bit_cnt == 5'd23);

  always_ff @(posedge clk_out) begin
    if (reset) begin
      state    <= ST_START;
      spi_cs_n <= 1'b1;
      spi_sclk <= 1'b0;
      hdr_q    <= {CMD_READ, FLASH_BASE};
      bit_cnt  <= '0;
      word_cnt <= '0;
      wr_en    <= 1'b0;
      loaded   <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      case (state)
        ST_START: begin
          // select the flash, first command bit is already on mosi
          spi_cs_n <= 1'b0;
          state    <= ST_CMD;
        end
        ST_CMD, ST_ADDR: begin
          spi_sclk <= rise;
          if (!rise) begin
            hdr_q   <= {hdr_q[30:0], 1'b0};
            bit_cnt <= bit_cnt + 5'd1;
            if (hdr_last) begin
              bit_cnt <= '0;
              state   <= (state == ST_CMD) ? ST_ADDR : ST_DATA;
            end
          end
        end
        ST_DATA: begin
          spi_sclk <= rise;
          if (rise) begin
            // 16th bit sampled here, word goes to ram next cycle
            wr_en <= (bit_cnt == 5'd15);
          end else begin
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == 5'd15) begin
              bit_cnt  <= '0;
              word_cnt <= word_cnt + 1'b1;
              if (word_cnt == VRAM_AW'(NUM_WORDS - 1)) begin
                spi_cs_n <= 1'b1;
                loaded   <= 1'b1;
                state    <= ST_DONE;
              end
            end
          end
        end
        default: begin
          // stay deselected until the next reset
          spi_sclk <= 1'b0;
        end
      endcase
    end
  end

  // incoming word shift and ram write payload
  always_ff @(posedge clk_out) begin
    if (state == ST_DATA && rise) begin
      word_q  <= word_next;
      wr_data <= word_next;
      wr_addr <= word_cnt;
    end
  end

  // image is written once, nothing may reach the ram after load
  a_no_write_after_load: assert property (
    @(posedge clk_out) disable iff (reset) loaded |-> !wr_en
  ) else $error("loader wrote video ram after loaded");

endmodule

//--- design/scan_timing.sv
`timescale 1ns/1ps

module scan_timing (
  input  logic           clk_out,
  input  logic           reset,
  input  logic           run,
  output vga_pkg::scan_t scan,
  output logic           frame_done
);
  import vga_pkg::*;

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       line_end;
  logic       frame_end;
  scan_t      scan_raw;

  assign line_end  = (h_cnt == 10'(H_TOTAL - 1));
  assign frame_end = line_end && (v_cnt == 10'(V_TOTAL - 1));

  // counters park at the origin while stopped
  always_ff @(posedge clk_out) begin
    if (reset || !run) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      v_cnt <= frame_end ? 10'd0 : v_cnt + 10'd1;
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  // flags decoded straight from the counters
  always_comb begin
    scan_raw.h       = h_cnt;
    scan_raw.v       = v_cnt;
    scan_raw.display = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    scan_raw.hsync_n = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
    scan_raw.vsync_n = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
  end

  // blank and syncs released when not running
  assign scan       = run ? scan_raw : SCAN_IDLE;
  assign frame_done = run && frame_end;

  a_h_in_range: assert property (
    @(posedge clk_out) disable iff (reset) h_cnt < H_TOTAL
  ) else $error("horizontal counter past line end");

endmodule

//--- design/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch (
  input  logic                        clk_out,
  input  logic                        reset,
  input  vga_pkg::scan_t              scan,
  output logic [vga_pkg::VRAM_AW-1:0] rd_addr,
  input  logic [15:0]                 rd_data,
  output vga_pkg::rgb_t               rgb
);
  import vga_pkg::*;

  // stored row is 160 pixels, two per word
  localparam int ROW_WORDS = 80;

  scan_t      scan_d;
  logic [7:0] pixel;

  // stage 1, each stored pixel covers a 4x4 screen block
  always_ff @(posedge clk_out) begin
    if (scan.display) begin
      rd_addr <= VRAM_AW'(ROW_WORDS * scan.v[9:2] + scan.h[9:3]);
    end else begin
      rd_addr <= '0;
    end
  end

  // position travels with the read so stage 3 sees the matching word
  stage_delay #(
    .payload_t (scan_t),
    .DEPTH     (PIPE_LAT - 1),
    .IDLE      (SCAN_IDLE)
  ) u_scan_delay (
    .clk_out  (clk_out),
    .reset    (reset),
    .in_data  (scan),
    .out_data (scan_d)
  );

  // left pixel in the high byte
  assign pixel = scan_d.h[2] ? rd_data[7:0] : rd_data[15:8];

  // stage 3, expand rrggbb and blank outside the visible area
  always_ff @(posedge clk_out) begin
    if (reset) begin
      rgb <= '0;
    end else if (scan_d.display) begin
      rgb.red   <= expand_channel(pixel[5:4]);
      rgb.green <= expand_channel(pixel[3:2]);
      rgb.blue  <= expand_channel(pixel[1:0]);
    end else begin
      rgb <= '0;
    end
  end

endmodule

//--- design/apb_video_regs.sv
`timescale 1ns/1ps

module apb_video_regs (
  input  logic        clk_out,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        loaded,
  input  logic        frame_done,
  output logic        scan_en
);

  localparam logic [3:0] ADDR_CTRL   = 4'h0;
  localparam logic [3:0] ADDR_STATUS = 4'h4;
  localparam logic [3:0] ADDR_FRAMES = 4'h8;

  logic        access;
  logic        addr_ok;
  logic [15:0] frame_cnt;

  // zero wait states, the access phase is the completing cycle
  assign access  = psel && penable;
  assign addr_ok = (paddr == ADDR_CTRL) || (paddr == ADDR_STATUS) || (paddr == ADDR_FRAMES);
  assign pready  = 1'b1;
  assign pslverr = access && !addr_ok;

  always_ff @(posedge clk_out) begin
    if (reset) begin
      scan_en   <= 1'b0;
      frame_cnt <= '0;
    end else begin
      if (access && pwrite && paddr == ADDR_CTRL) begin
        scan_en <= pwdata[0];
      end
      // any write clears, a coincident frame end is dropped
      if (access && pwrite && paddr == ADDR_FRAMES) begin
        frame_cnt <= '0;
      end else if (frame_done) begin
        frame_cnt <= frame_cnt + 16'd1;
      end
    end
  end

  // read mux, status and frame count are read-only
  always_comb begin
    case (paddr)
      ADDR_CTRL:   prdata = {31'b0, scan_en};
      ADDR_STATUS: prdata = {31'b0, loaded};
      ADDR_FRAMES: prdata = {16'b0, frame_cnt};
      default:     prdata = '0;
    endcase
  end

  a_penable_needs_psel: assert property (
    @(posedge clk_out) disable iff (reset) penable |-> psel
  ) else $error("apb penable without psel");

endmodule

//--- design/vga_computer.sv
`timescale 1ns/1ps

module vga_computer #(
  parameter logic [23:0] FLASH_BASE = 24'h100000,
  parameter int          NUM_WORDS  = vga_pkg::VRAM_WORDS
) (
  input  logic          clk_out,
  input  logic          reset,
  output logic          spi_cs_n,
  output logic          spi_sclk,
  output logic          spi_mosi,
  input  logic          spi_miso,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  logic [3:0]    paddr,
  input  logic [31:0]   pwdata,
  output logic [31:0]   prdata,
  output logic          pready,
  output logic          pslverr,
  output vga_pkg::rgb_t rgb,
  output logic          hsync_n,
  output logic          vsync_n
);
  import vga_pkg::*;

  logic               wr_en;
  logic [VRAM_AW-1:0] wr_addr;
  logic [15:0]        wr_data;
  logic [VRAM_AW-1:0] rd_addr;
  logic [15:0]        rd_data;
  logic               loaded;
  logic               scan_en;
  logic               run;
  logic               frame_done;
  scan_t              scan;
  scan_t              sync_q;

  // video starts only once the image is in ram and the host allows it
  assign run = loaded && scan_en;

  spi_flash_loader #(
    .FLASH_BASE (FLASH_BASE),
    .NUM_WORDS  (NUM_WORDS)
  ) u_loader (
    .clk_out  (clk_out),
    .reset    (reset),
    .spi_cs_n (spi_cs_n),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .loaded   (loaded)
  );

  video_ram #(
    .NUM_WORDS (NUM_WORDS)
  ) u_vram (
    .clk_out (clk_out),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  scan_timing u_scan (
    .clk_out    (clk_out),
    .reset      (reset),
    .run        (run),
    .scan       (scan),
    .frame_done (frame_done)
  );

  pixel_fetch u_fetch (
    .clk_out (clk_out),
    .reset   (reset),
    .scan    (scan),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rgb     (rgb)
  );

  // syncs follow the full fetch latency to line up with rgb
  stage_delay #(
    .payload_t (scan_t),
    .DEPTH     (PIPE_LAT),
    .IDLE      (SCAN_IDLE)
  ) u_sync_delay (
    .clk_out  (clk_out),
    .reset    (reset),
    .in_data  (scan),
    .out_data (sync_q)
  );

  assign hsync_n = sync_q.hsync_n;
  assign vsync_n = sync_q.vsync_n;

  apb_video_regs u_regs (
    .clk_out    (clk_out),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .loaded     (loaded),
    .frame_done (frame_done),
    .scan_en    (scan_en)
  );

endmodule

//--- verification/tb_vga_computer.sv
`timescale 1ns/1ps

module tb_vga_computer;

  // video timing at the pins in clocks
  localparam int H_PERIOD    = 800;
  localparam int H_PULSE     = 96;
  localparam int V_PERIOD    = 420000;
  localparam int V_PULSE     = 1600;
  localparam int VSYNC_LINE  = 490;
  localparam int PIPE_CYCLES = 3;
  // falling clock edges from enable to the first vsync fall
  localparam int ENABLE_TO_VS = VSYNC_LINE * H_PERIOD + PIPE_CYCLES + 1;
  localparam int FRAME_LIMIT  = V_PERIOD + 2000;

  localparam logic [23:0] FLASH_BASE = 24'h100000;
  localparam int          IMG_WORDS  = 9600;
  localparam logic [31:0] LCG_SEED   = 32'd85948;
  // header plus image at two clocks per bit
  localparam int LOAD_LIMIT   = 2 * (32 + 16 * IMG_WORDS) + 64;
  localparam int APB_LIMIT    = 16;
  localparam int GOLDEN_DEPTH = 32;

  logic        clk_out = 1'b0;
  logic        reset;
  logic        spi_cs_n;
  logic        spi_sclk;
  logic        spi_mosi;
  logic        spi_miso;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [11:0] rgb;
  logic        hsync_n;
  logic        vsync_n;

  int          errors = 0;
  logic [15:0] img [IMG_WORDS];
  logic [47:0] golden [GOLDEN_DEPTH];

  // flash model state
  logic [31:0] flash_hdr;
  logic [31:0] hdr_word;
  int          hdr_cnt;
  int          data_bit;
  logic        hdr_done = 1'b0;

  // monitor controls and state
  logic quiet_check = 1'b0;
  logic sync_check  = 1'b0;
  logic hs_prev;
  logic vs_prev;
  logic hs_armed;
  logic vs_armed;
  int   hs_period;
  int   hs_low;
  int   vs_period;
  int   vs_low;

  vga_computer #(
    .FLASH_BASE (FLASH_BASE)
  ) u_vga_computer (
    .clk_out  (clk_out),
    .reset    (reset),
    .spi_cs_n (spi_cs_n),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .rgb      (rgb),
    .hsync_n  (hsync_n),
    .vsync_n  (vsync_n)
  );

  always #50 clk_out = ~clk_out;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd69069 + 32'd1;
  endfunction

  // 4x4 screen blocks per stored pixel with 80 words per stored row and the left pixel high
  function automatic logic [11:0] expected_rgb(input int row, input int col);
    logic [15:0] word;
    logic [7:0]  pix;
    if (row >= 480 || col >= 640) begin
      return 12'h000;
    end
    word = img[80 * (row / 4) + col / 8];
    pix  = (col % 8 < 4) ? word[15:8] : word[7:0];
    return {pix[5:4], pix[5:4], pix[3:2], pix[3:2], pix[1:0], pix[1:0]};
  endfunction

  // serial image stream with the msb of each word first
  function automatic logic flash_bit(input int n);
    if (n / 16 >= IMG_WORDS) begin
      return 1'b0;
    end
    return img[n / 16][15 - n % 16];
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("run aborted at %0t ns: %s", $time, what);
    $display("errors: %0d", errors);
    $display("Test FAILED");
    $finish;
  endtask

  // setup, access, then release on the completing edge
  task automatic apb_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    int wait_cnt;
    @(posedge clk_out);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk_out);
    penable <= 1'b1;
    @(negedge clk_out);
    wait_cnt = 0;
    while (!pready && wait_cnt < APB_LIMIT) begin
      @(negedge clk_out);
      wait_cnt++;
    end
    if (!pready) begin
      abort_run("apb slave never raised pready");
    end
    // the register block completes every access without wait states
    check_value(wait_cnt, 0, "apb wait states");
    rdata = prdata;
    err   = pslverr;
    @(posedge clk_out);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_check(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp_data, input logic exp_err, input string what);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(wr, addr, wdata, rdata, err);
    check_value(err, exp_err, {what, " pslverr"});
    if (!wr) begin
      check_value(rdata, exp_data, {what, " prdata"});
    end
  endtask

  // returns the number of falling clock edges up to and including the vsync fall
  task automatic wait_vsync_fall(output int cycles);
    logic prev;
    logic found;
    prev   = vsync_n;
    cycles = 0;
    found  = 1'b0;
    while (!found && cycles < FRAME_LIMIT) begin
      @(negedge clk_out);
      cycles++;
      found = prev && !vsync_n;
      prev  = vsync_n;
    end
    if (!found) begin
      abort_run("vsync_n never fell");
    end
  endtask

  // flash model samples mosi in the sclk high cycle and changes miso as sclk falls
  always @(posedge clk_out) begin
    if (reset || spi_cs_n) begin
      hdr_cnt  <= 0;
      spi_miso <= 1'b0;
    end else if (spi_sclk) begin
      if (hdr_cnt < 32) begin
        hdr_word = {flash_hdr[30:0], spi_mosi};
        flash_hdr <= hdr_word;
        hdr_cnt   <= hdr_cnt + 1;
        if (hdr_cnt == 31) begin
          check_value(hdr_word[31:24], 8'h03, "flash command");
          check_value(hdr_word[23:0], FLASH_BASE, "flash address");
          hdr_done <= 1'b1;
          spi_miso <= flash_bit(0);
          data_bit <= 1;
        end
      end else begin
        spi_miso <= flash_bit(data_bit);
        data_bit <= data_bit + 1;
      end
    end
  end

  // video pins stay idle while the scan is stopped
  always @(negedge clk_out) begin
    if (quiet_check) begin
      assert (hsync_n && vsync_n && rgb == 12'h000) else begin
        errors++;
        $display("mismatch at %0t ns: video pins active while the scan is stopped", $time);
      end
    end
  end

  // sync pulse widths and periods
  always @(negedge clk_out) begin
    if (!sync_check) begin
      hs_armed = 1'b0;
      vs_armed = 1'b0;
      hs_prev  = 1'b1;
      vs_prev  = 1'b1;
    end else begin
      hs_period++;
      vs_period++;
      if (hs_prev && !hsync_n) begin
        if (hs_armed) begin
          check_value(hs_period, H_PERIOD, "hsync period");
        end
        hs_armed  = 1'b1;
        hs_period = 0;
        hs_low    = 1;
      end else if (!hsync_n) begin
        hs_low++;
      end else if (!hs_prev && hs_armed) begin
        check_value(hs_low, H_PULSE, "hsync low time");
      end
      if (vs_prev && !vsync_n) begin
        if (vs_armed) begin
          check_value(vs_period, V_PERIOD, "vsync period");
        end
        vs_armed  = 1'b1;
        vs_period = 0;
        vs_low    = 1;
      end else if (!vsync_n) begin
        vs_low++;
      end else if (!vs_prev && vs_armed) begin
        check_value(vs_low, V_PULSE, "vsync low time");
      end
      hs_prev = hsync_n;
      vs_prev = vsync_n;
    end
  end

  initial begin
    int          i;
    int          cycles;
    int          pos;
    int          target;
    int          row;
    int          col;
    int          vs_falls;
    int          cur_frame;
    logic [31:0] lcg_state;
    logic [31:0] rdata;
    logic        err;
    logic [47:0] rec;

    reset    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    spi_miso = 1'b0;

    // word i of the flash image is the i-th lcg output from the base address
    lcg_state = LCG_SEED;
    for (i = 0; i < IMG_WORDS; i++) begin
      lcg_state = lcg_next(lcg_state);
      img[i]    = lcg_state[31:16];
    end
    for (i = 0; i < GOLDEN_DEPTH; i++) begin
      golden[i] = '0;
    end
    $readmemh("verification/vga_golden.txt", golden);
    if (golden[0][47:44] == 4'h0) begin
      abort_run("golden file is missing or empty");
    end

    repeat (16) @(posedge clk_out);
    reset <= 1'b0;
    @(negedge clk_out);
    check_value(spi_cs_n, 1'b1, "spi_cs_n after reset");
    check_value(spi_sclk, 1'b0, "spi_sclk after reset");
    check_value(hsync_n, 1'b1, "hsync_n after reset");
    check_value(vsync_n, 1'b1, "vsync_n after reset");
    check_value(rgb, 12'h000, "rgb after reset");
    check_value(pslverr, 1'b0, "pslverr after reset");
    quiet_check = 1'b1;

    // golden register traffic runs before the image is loaded
    for (i = 0; i < GOLDEN_DEPTH; i++) begin
      rec = golden[i];
      if (rec[47:44] == 4'hA) begin
        apb_check(rec[40], rec[39:36], {16'h0, rec[31:16]}, {16'h0, rec[15:0]}, rec[32],
                  "golden apb");
      end
    end

    // poll status until the loader is done
    cycles = 0;
    rdata  = '0;
    while (!rdata[0] && cycles < LOAD_LIMIT) begin
      apb_transfer(1'b0, 4'h4, 32'h0, rdata, err);
      cycles += 3;
    end
    if (!rdata[0]) begin
      abort_run("STATUS loaded bit never set");
    end
    assert (hdr_done && data_bit >= 16 * IMG_WORDS) else begin
      errors++;
      $display("flash model never saw a full read of the image");
    end
    check_value(spi_cs_n, 1'b1, "spi_cs_n after load");
    quiet_check = 1'b0;

    // the first frame after enable begins at (0,0)
    apb_check(1'b1, 4'h0, 32'h1, 32'h0, 1'b0, "enable scan");
    sync_check = 1'b1;
    wait_vsync_fall(cycles);
    check_value(cycles, ENABLE_TO_VS, "clocks from enable to vsync fall");
    vs_falls  = 1;
    cur_frame = 0;
    pos       = 0;

    // probes count from the vsync fall and line 0 begins 35 lines later
    for (i = 0; i < GOLDEN_DEPTH; i++) begin
      rec = golden[i];
      if (rec[47:44] == 4'hB) begin
        while (rec[43:40] > cur_frame) begin
          wait_vsync_fall(cycles);
          vs_falls++;
          cur_frame++;
          pos = 0;
        end
        row    = rec[39:28];
        col    = rec[27:16];
        target = (525 - VSYNC_LINE) * H_PERIOD + row * H_PERIOD + col;
        if (target < pos) begin
          abort_run("golden probes are out of order");
        end
        while (pos < target && pos < FRAME_LIMIT) begin
          @(negedge clk_out);
          pos++;
        end
        check_value(rec[11:0], expected_rgb(row, col), "golden probe against image");
        check_value(rgb, rec[11:0], $sformatf("rgb at row %0d col %0d", row, col));
      end
    end

    // completed frames so far is one less than the vsync falls seen
    wait_vsync_fall(cycles);
    vs_falls++;
    apb_check(1'b0, 4'h8, 32'h0, vs_falls - 1, 1'b0, "frame count");
    apb_check(1'b1, 4'h8, 32'h0, 32'h0, 1'b0, "frame count clear");
    apb_check(1'b0, 4'h8, 32'h0, 32'h0, 1'b0, "frame count after clear");

    // disable drains the pipeline to idle
    sync_check = 1'b0;
    apb_check(1'b1, 4'h0, 32'h0, 32'h0, 1'b0, "disable scan");
    pos = 0;
    while (!(hsync_n && vsync_n && rgb == 12'h000) && pos <= PIPE_CYCLES + 1) begin
      @(negedge clk_out);
      pos++;
    end
    assert (pos <= PIPE_CYCLES + 1) else begin
      errors++;
      $display("video pins did not return to idle after the scan was disabled");
    end
    quiet_check = 1'b1;
    repeat (1000) @(negedge clk_out);
    quiet_check = 1'b0;
    apb_check(1'b0, 4'h8, 32'h0, 32'h0, 1'b0, "frame count while disabled");

    // re-enable restarts from the origin
    apb_check(1'b1, 4'h0, 32'h1, 32'h0, 1'b0, "re-enable scan");
    sync_check = 1'b1;
    wait_vsync_fall(cycles);
    check_value(cycles, ENABLE_TO_VS, "clocks from re-enable to vsync fall");
    check_value(spi_cs_n, 1'b1, "spi_cs_n at end");

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verification/vga_golden.txt
// apb:   A W R E DDDD PPPP  W write, R paddr, E pslverr, DDDD pwdata, PPPP prdata on reads
// probe: B F RRR CCC VVVV   F frame after enable, RRR row, CCC column, VVVV rgb
A04000000000
A10000010000
A00000000001
A10000000000
A00000000000
A0C100000000
A12100AB0000
A08000000000
B00000000A05
B0001009050F
B000200E055F
B00030050555
B00642BC0000
B10000030A05
B100200C055F
B11E400C0000

//--- vga_computer.f
design/vga_pkg.sv
design/stage_delay.sv
design/video_ram.sv
design/spi_flash_loader.sv
design/scan_timing.sv
design/pixel_fetch.sv
design/apb_video_regs.sv
design/vga_computer.sv
verification/tb_vga_computer.sv

//--- Bender.yml
package:
  name: vga_computer

sources:
  - design/vga_pkg.sv
  - design/stage_delay.sv
  - design/video_ram.sv
  - design/spi_flash_loader.sv
  - design/scan_timing.sv
  - design/pixel_fetch.sv
  - design/apb_video_regs.sv
  - design/vga_computer.sv
  - target: test
    files:
      - verification/tb_vga_computer.sv
